/* design/dma_axi_pkg.sv */
`include "dma_macros.svh"

package dma_axi_pkg;

   // AXI4 read address channel
   typedef struct packed {
      logic [`DMA_ID_W-1:0]   id;
      logic [`DMA_ADDR_W-1:0] addr;
      logic [7:0]             len;
      logic [2:0]             size;
      logic [1:0]             burst;
   } axi_ar_t;

   // AXI4 read data channel
   typedef struct packed {
      logic [`DMA_ID_W-1:0]   id;
      logic [`DMA_DATA_W-1:0] data;
      logic [1:0]             resp;
      logic                   last;
   } axi_r_t;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
   } lite_aw_t;

   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
   } lite_w_t;

   typedef struct packed {
      logic [1:0] resp;
   } lite_b_t;

   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
   } lite_ar_t;

   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic [1:0]             resp;
   } lite_r_t;

   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   localparam logic [2:0] AXI_SIZE_4B    = 3'b010;
   localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

   // Register map
   localparam logic [7:0] CSR_ADDR   = 8'h00;
   localparam logic [7:0] CSR_LEN    = 8'h04;
   localparam logic [7:0] CSR_MAXLEN = 8'h08;
   localparam logic [7:0] CSR_CTRL   = 8'h0c;
   localparam logic [7:0] CSR_REMAIN = 8'h10;

endpackage

/* design/dma_axi_rd_master.sv */
`include "dma_macros.svh"

module dma_axi_rd_master import dma_axi_pkg::*, dma_ctrl_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  dma_cmd_t  cmd_i,
   input  logic      cmd_empty_i,
   output logic      cmd_pop_o,
   output axi_ar_t   ar_o,
   output logic      arvalid_o,
   input  logic      arready_i,
   input  axi_r_t    r_i,
   input  logic      rvalid_i,
   output logic      rready_o,
   output dma_beat_t beat_o,
   output logic      beat_push_o,
   input  logic      beat_full_i,
   output logic      final_done_o
);

   // Each outstanding burst holds at least one slot of FIFO credit
   localparam int QDEPTH = 1 << `DMA_FIFO_AW;

   logic [QDEPTH-1:0]       final_q;
   logic [`DMA_FIFO_AW-1:0] fq_wr_q;
   logic [`DMA_FIFO_AW-1:0] fq_rd_q;
   logic                    head_final;
   logic                    r_last_acc;

   // Next command waits for the current AR handshake
   assign cmd_pop_o = !cmd_empty_i && (!arvalid_o || arready_i);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         arvalid_o <= 1'b0;
      end else if (cmd_pop_o) begin
         arvalid_o <= 1'b1;
      end else if (arready_i) begin
         arvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_pop_o) begin
         ar_o <= '{id: '0,
                   addr: cmd_i.addr,
                   len: 8'(cmd_i.beats - 1'b1),
                   size: AXI_SIZE_4B,
                   burst: AXI_BURST_INCR};
         final_q[fq_wr_q] <= cmd_i.is_final;
      end
   end

   // Final-flag queue, one entry per burst in order
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         fq_wr_q <= '0;
         fq_rd_q <= '0;
      end else begin
         if (cmd_pop_o) begin
            fq_wr_q <= fq_wr_q + 1'b1;
         end
         if (r_last_acc) begin
            fq_rd_q <= fq_rd_q + 1'b1;
         end
      end
   end

   assign rready_o     = !beat_full_i;
   assign beat_push_o  = rvalid_i && !beat_full_i;
   assign r_last_acc   = beat_push_o && r_i.last;
   assign head_final   = final_q[fq_rd_q];
   assign beat_o       = '{data: r_i.data, last: r_i.last && head_final};
   assign final_done_o = r_last_acc && head_final;

   a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o));

endmodule

/* design/dma_burst_sched.sv */
`include "dma_macros.svh"

module dma_burst_sched import dma_ctrl_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  dma_desc_t              desc_i,
   output dma_cmd_t               cmd_o,
   output logic                   cmd_valid_o,
   input  logic                   cmd_full_i,
   input  logic                   cmd_empty_i,
   input  logic [`DMA_FIFO_AW:0]  fifo_level_i,
   input  logic                   beat_push_i,
   input  logic                   final_done_i,
   output logic                   busy_o,
   output logic [`DMA_RLEN_W-1:0] remain_o
);

   localparam int DEPTH = 1 << `DMA_FIFO_AW;

   typedef enum logic {
      IDLE,
      RUN
   } state_t;

   state_t                 state_q;
   logic [`DMA_RLEN_W-1:0] remain_q;
   logic [`DMA_ADDR_W-1:0] addr_q;
   logic [`DMA_LEN_W:0]    max_q;
   logic [`DMA_FIFO_AW:0]  inflight_q;
   logic [`DMA_FIFO_AW:0]  inflight_nxt;
   logic [`DMA_FIFO_AW:0]  free_space;
   logic [`DMA_RLEN_W-1:0] free_ext;
   logic [`DMA_RLEN_W-1:0] max_ext;
   logic [`DMA_LEN_W:0]    burst_len;
   logic                   issue;
   logic                   done;

   // Room left once every reserved beat has landed
   assign free_space = (`DMA_FIFO_AW+1)'(DEPTH) - fifo_level_i - inflight_q;
   assign free_ext   = `DMA_RLEN_W'(free_space);
   assign max_ext    = `DMA_RLEN_W'(max_q);

   always_comb begin
      burst_len = '0;
      if (remain_q <= max_ext && remain_q <= free_ext) begin
         burst_len = remain_q[`DMA_LEN_W:0];
      end else if (free_ext >= max_ext) begin
         burst_len = max_q;
      end
   end

   assign issue = state_q == RUN && remain_q != '0 && burst_len != '0 && !cmd_full_i;
   assign done  = state_q == RUN && remain_q == '0 && cmd_empty_i && final_done_i;

   // Beats reserved but not yet pushed into the data FIFO
   always_comb begin
      inflight_nxt = inflight_q - (`DMA_FIFO_AW+1)'(beat_push_i);
      if (issue) begin
         inflight_nxt = inflight_nxt + (`DMA_FIFO_AW+1)'(burst_len);
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q    <= IDLE;
         remain_q   <= '0;
         addr_q     <= '0;
         max_q      <= '0;
         inflight_q <= '0;
      end else begin
         inflight_q <= inflight_nxt;
         case (state_q)
            IDLE: begin
               if (desc_i.start && desc_i.len != '0) begin
                  remain_q <= desc_i.len;
                  addr_q   <= desc_i.addr;
                  max_q    <= desc_i.max_len;
                  state_q  <= RUN;
               end
            end
            default: begin
               if (issue) begin
                  remain_q <= remain_q - `DMA_RLEN_W'(burst_len);
                  addr_q   <= addr_q + `DMA_ADDR_W'({burst_len, 2'b00});
               end
               if (done) begin
                  state_q <= IDLE;
               end
            end
         endcase
      end
   end

   assign cmd_valid_o = issue;
   assign cmd_o       = '{addr: addr_q,
                          beats: burst_len,
                          is_final: `DMA_RLEN_W'(burst_len) == remain_q};
   assign busy_o      = state_q == RUN;
   assign remain_o    = remain_q;

   // Credit never promises more than the data FIFO can hold
   a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      int'(inflight_q) + int'(fifo_level_i) <= DEPTH);

   a_burst_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmd_valid_o |-> cmd_o.beats <= max_q);

endmodule

/* design/dma_csr.sv */
`include "dma_macros.svh"

module dma_csr import dma_axi_pkg::*, dma_ctrl_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  lite_aw_t               aw_i,
   input  logic                   awvalid_i,
   output logic                   awready_o,
   input  lite_w_t                w_i,
   input  logic                   wvalid_i,
   output logic                   wready_o,
   output lite_b_t                b_o,
   output logic                   bvalid_o,
   input  logic                   bready_i,
   input  lite_ar_t               ar_i,
   input  logic                   arvalid_i,
   output logic                   arready_o,
   output lite_r_t                r_o,
   output logic                   rvalid_o,
   input  logic                   rready_i,
   output dma_desc_t              desc_o,
   input  logic                   busy_i,
   input  logic [`DMA_RLEN_W-1:0] remain_i
);

   localparam int MAX_BURST = 1 << `DMA_LEN_W;

   logic                   wr_acc;
   logic                   rd_acc;
   logic [`DMA_DATA_W-1:0] wdata;
   logic [`DMA_ADDR_W-1:0] addr_q;
   logic [`DMA_RLEN_W-1:0] len_q;
   logic [`DMA_LEN_W:0]    max_q;
   logic [`DMA_LEN_W:0]    max_clamped;
   logic                   start_q;
   logic [`DMA_DATA_W-1:0] rdata_mux;
   logic [`DMA_DATA_W-1:0] rdata_q;

   // Address and data taken in the same cycle
   assign wr_acc    = awvalid_i && wvalid_i && !bvalid_o;
   assign awready_o = wr_acc;
   assign wready_o  = wr_acc;
   assign rd_acc    = arvalid_i && !rvalid_o;
   assign arready_o = !rvalid_o;
   assign wdata     = w_i.data;

   // Burst limit kept within 1..16
   always_comb begin
      if (wdata == '0) begin
         max_clamped = (`DMA_LEN_W+1)'(1);
      end else if (wdata > MAX_BURST) begin
         max_clamped = (`DMA_LEN_W+1)'(MAX_BURST);
      end else begin
         max_clamped = wdata[`DMA_LEN_W:0];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         addr_q   <= '0;
         len_q    <= '0;
         max_q    <= (`DMA_LEN_W+1)'(MAX_BURST);
         start_q  <= 1'b0;
         bvalid_o <= 1'b0;
      end else begin
         start_q <= 1'b0;
         if (wr_acc) begin
            bvalid_o <= 1'b1;
            case (aw_i.addr[7:0])
               CSR_ADDR:   addr_q  <= wdata;
               CSR_LEN:    len_q   <= wdata[`DMA_RLEN_W-1:0];
               CSR_MAXLEN: max_q   <= max_clamped;
               // start is dropped while a transfer runs
               CSR_CTRL:   start_q <= wdata[0] && !busy_i && !start_q;
               default: ;
            endcase
         end else if (bready_i) begin
            bvalid_o <= 1'b0;
         end
      end
   end

   always_comb begin
      case (ar_i.addr[7:0])
         CSR_ADDR:   rdata_mux = addr_q;
         CSR_LEN:    rdata_mux = `DMA_DATA_W'(len_q);
         CSR_MAXLEN: rdata_mux = `DMA_DATA_W'(max_q);
         CSR_CTRL:   rdata_mux = `DMA_DATA_W'(busy_i);
         CSR_REMAIN: rdata_mux = `DMA_DATA_W'(remain_i);
         default:    rdata_mux = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_o <= 1'b0;
      end else if (rd_acc) begin
         rvalid_o <= 1'b1;
      end else if (rready_i) begin
         rvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_acc) begin
         rdata_q <= rdata_mux;
      end
   end

   assign b_o    = '{resp: AXI_RESP_OKAY};
   assign r_o    = '{data: rdata_q, resp: AXI_RESP_OKAY};
   assign desc_o = '{addr: addr_q, len: len_q, max_len: max_q, start: start_q};

   // A write response only ever follows an accepted write
   a_bvalid_after_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(bvalid_o) |-> $past(wr_acc));

endmodule

/* design/dma_ctrl_pkg.sv */
`include "dma_macros.svh"

package dma_ctrl_pkg;

   // Transfer as programmed by software
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_RLEN_W-1:0] len;
      logic [`DMA_LEN_W:0]    max_len;
      logic                   start;
   } dma_desc_t;

   // One burst handed to the read master
   typedef struct packed {
      logic [`DMA_ADDR_W-1:0] addr;
      logic [`DMA_LEN_W:0]    beats;
      logic                   is_final;
   } dma_cmd_t;

   // Stream word
   typedef struct packed {
      logic [`DMA_DATA_W-1:0] data;
      logic                   last;
   } dma_beat_t;

endpackage

/* design/dma_read_top.sv */
`include "dma_macros.svh"

module dma_read_top import dma_axi_pkg::*, dma_ctrl_pkg::*; (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   // Configuration port
   input  lite_aw_t               s_lite_aw_i,
   input  logic                   s_lite_awvalid_i,
   output logic                   s_lite_awready_o,
   input  lite_w_t                s_lite_w_i,
   input  logic                   s_lite_wvalid_i,
   output logic                   s_lite_wready_o,
   output lite_b_t                s_lite_b_o,
   output logic                   s_lite_bvalid_o,
   input  logic                   s_lite_bready_i,
   input  lite_ar_t               s_lite_ar_i,
   input  logic                   s_lite_arvalid_i,
   output logic                   s_lite_arready_o,
   output lite_r_t                s_lite_r_o,
   output logic                   s_lite_rvalid_o,
   input  logic                   s_lite_rready_i,
   // Memory read port
   output axi_ar_t                m_axi_ar_o,
   output logic                   m_axi_arvalid_o,
   input  logic                   m_axi_arready_i,
   input  axi_r_t                 m_axi_r_i,
   input  logic                   m_axi_rvalid_i,
   output logic                   m_axi_rready_o,
   // Stream out
   output logic [`DMA_DATA_W-1:0] m_axis_tdata_o,
   output logic                   m_axis_tlast_o,
   output logic                   m_axis_tvalid_o,
   input  logic                   m_axis_tready_i
);

   dma_desc_t              desc;
   logic                   busy;
   logic [`DMA_RLEN_W-1:0] remain;
   dma_cmd_t               sched_cmd;
   logic                   sched_cmd_valid;
   logic                   cmd_full;
   logic                   cmd_empty;
   dma_cmd_t               cmd_head;
   logic                   cmd_pop;
   dma_beat_t              beat_in;
   logic                   beat_push;
   logic                   beat_full;
   dma_beat_t              beat_out;
   logic                   data_empty;
   logic                   data_pop;
   logic [`DMA_FIFO_AW:0]  data_level;
   logic                   final_done;

   dma_csr csr_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .aw_i      (s_lite_aw_i),
      .awvalid_i (s_lite_awvalid_i),
      .awready_o (s_lite_awready_o),
      .w_i       (s_lite_w_i),
      .wvalid_i  (s_lite_wvalid_i),
      .wready_o  (s_lite_wready_o),
      .b_o       (s_lite_b_o),
      .bvalid_o  (s_lite_bvalid_o),
      .bready_i  (s_lite_bready_i),
      .ar_i      (s_lite_ar_i),
      .arvalid_i (s_lite_arvalid_i),
      .arready_o (s_lite_arready_o),
      .r_o       (s_lite_r_o),
      .rvalid_o  (s_lite_rvalid_o),
      .rready_i  (s_lite_rready_i),
      .desc_o    (desc),
      .busy_i    (busy),
      .remain_i  (remain)
   );

   dma_burst_sched sched_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .desc_i       (desc),
      .cmd_o        (sched_cmd),
      .cmd_valid_o  (sched_cmd_valid),
      .cmd_full_i   (cmd_full),
      .cmd_empty_i  (cmd_empty),
      .fifo_level_i (data_level),
      .beat_push_i  (beat_push),
      .final_done_i (final_done),
      .busy_o       (busy),
      .remain_o     (remain)
   );

   dma_sync_fifo #(
      .T      (dma_cmd_t),
      .ADDR_W (`DMA_CMD_AW)
   ) cmd_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (sched_cmd_valid),
      .data_i  (sched_cmd),
      .full_o  (cmd_full),
      .pop_i   (cmd_pop),
      .data_o  (cmd_head),
      .empty_o (cmd_empty),
      .level_o ()
   );

   dma_axi_rd_master rd_master_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_i        (cmd_head),
      .cmd_empty_i  (cmd_empty),
      .cmd_pop_o    (cmd_pop),
      .ar_o         (m_axi_ar_o),
      .arvalid_o    (m_axi_arvalid_o),
      .arready_i    (m_axi_arready_i),
      .r_i          (m_axi_r_i),
      .rvalid_i     (m_axi_rvalid_i),
      .rready_o     (m_axi_rready_o),
      .beat_o       (beat_in),
      .beat_push_o  (beat_push),
      .beat_full_i  (beat_full),
      .final_done_o (final_done)
   );

   dma_sync_fifo #(
      .T      (dma_beat_t),
      .ADDR_W (`DMA_FIFO_AW)
   ) data_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (beat_push),
      .data_i  (beat_in),
      .full_o  (beat_full),
      .pop_i   (data_pop),
      .data_o  (beat_out),
      .empty_o (data_empty),
      .level_o (data_level)
   );

   assign m_axis_tvalid_o = !data_empty;
   assign m_axis_tdata_o  = beat_out.data;
   assign m_axis_tlast_o  = beat_out.last;
   assign data_pop        = m_axis_tvalid_o && m_axis_tready_i;

endmodule

/* design/dma_sync_fifo.sv */
module dma_sync_fifo #(
   parameter type T      = logic,
   parameter int  ADDR_W = 2
) (
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  logic            push_i,
   input  T                data_i,
   output logic            full_o,
   input  logic            pop_i,
   output T                data_o,
   output logic            empty_o,
   output logic [ADDR_W:0] level_o
);

   localparam int DEPTH = 1 << ADDR_W;

   T                  mem [DEPTH];
   logic [ADDR_W-1:0] wr_ptr_q;
   logic [ADDR_W-1:0] rd_ptr_q;
   logic [ADDR_W:0]   count_q;

   assign full_o  = count_q == (ADDR_W+1)'(DEPTH);
   assign empty_o = count_q == '0;
   assign level_o = count_q;
   // Head entry visible without a read strobe
   assign data_o  = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q <= count_q + (ADDR_W+1)'(push_i) - (ADDR_W+1)'(pop_i);
      end
   end

   a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push_i |-> !full_o);

   a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

endmodule

/* dv/dma_axi_mem.sv */
`include "dma_macros.svh"

module dma_axi_mem import dma_axi_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  axi_ar_t ar_i,
   input  logic    arvalid_i,
   output logic    arready_o,
   output axi_r_t  r_o,
   output logic    rvalid_o,
   input  logic    rready_i
);

   localparam int LOG_DEPTH = 64;

   integer                 seed = 32'h6ab1f12f;
   logic                   arready_q = 1'b0;
   logic                   rvalid_q = 1'b0;
   axi_r_t                 r_q = '0;
   logic [`DMA_ADDR_W-1:0] pend_addr [$];
   logic [7:0]             pend_len [$];
   int                     beat = 0;
   logic [`DMA_ADDR_W-1:0] beat_addr;
   // AR log, read by the testbench
   logic [`DMA_ADDR_W-1:0] log_addr [LOG_DEPTH];
   logic [7:0]             log_len [LOG_DEPTH];
   // Size in the upper three bits, burst type below
   logic [4:0]             log_attr [LOG_DEPTH];
   int                     log_cnt = 0;

   assign arready_o = arready_q;
   assign rvalid_o  = rvalid_q;
   assign r_o       = r_q;

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         pend_addr.delete();
         pend_len.delete();
         beat = 0;
      end else begin
         if (arvalid_i && arready_q) begin
            pend_addr.push_back(ar_i.addr);
            pend_len.push_back(ar_i.len);
            if (log_cnt < LOG_DEPTH) begin
               log_addr[log_cnt] = ar_i.addr;
               log_len[log_cnt]  = ar_i.len;
               log_attr[log_cnt] = {ar_i.size, ar_i.burst};
            end
            log_cnt = log_cnt + 1;
         end
         // Retire the beat just taken
         if (rvalid_q && rready_i) begin
            if (r_q.last) begin
               void'(pend_addr.pop_front());
               void'(pend_len.pop_front());
               beat = 0;
            end else begin
               beat = beat + 1;
            end
         end
         // A presented beat holds until taken
         if (!rvalid_q || rready_i) begin
            if (pend_addr.size() > 0 && (($random(seed) & 3) != 0)) begin
               beat_addr = pend_addr[0] + 32'(beat * 4);
               r_q <= '{id: '0,
                        data: beat_addr ^ 32'hc0de0000,
                        resp: AXI_RESP_OKAY,
                        last: beat == int'(pend_len[0])};
               rvalid_q <= 1'b1;
            end else begin
               rvalid_q <= 1'b0;
            end
         end
         arready_q <= ($random(seed) & 3) != 0;
      end
   end

endmodule

/* dv/dma_tb.sv */
`include "dma_macros.svh"

module dma_tb import dma_axi_pkg::*;;

   // Words moved by all tests together
   localparam int TOTAL_WORDS     = 6 + 37 + 100 + 60;
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS;

   logic                   clk;
   logic                   rst_n;
   lite_aw_t               lite_aw;
   logic                   lite_awvalid;
   logic                   lite_awready;
   lite_w_t                lite_w;
   logic                   lite_wvalid;
   logic                   lite_wready;
   lite_b_t                lite_b;
   logic                   lite_bvalid;
   logic                   lite_bready;
   lite_ar_t               lite_ar;
   logic                   lite_arvalid;
   logic                   lite_arready;
   lite_r_t                lite_r;
   logic                   lite_rvalid;
   logic                   lite_rready;
   axi_ar_t                axi_ar;
   logic                   axi_arvalid;
   logic                   axi_arready;
   axi_r_t                 axi_r;
   logic                   axi_rvalid;
   logic                   axi_rready;
   logic [`DMA_DATA_W-1:0] tdata;
   logic                   tlast;
   logic                   tvalid;
   logic                   tready;
   integer                 seed;
   string                  cur_test;
   logic [`DMA_DATA_W-1:0] got_data [$];
   logic                   got_last [$];

   dma_read_top dma_read_top_i (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .s_lite_aw_i      (lite_aw),
      .s_lite_awvalid_i (lite_awvalid),
      .s_lite_awready_o (lite_awready),
      .s_lite_w_i       (lite_w),
      .s_lite_wvalid_i  (lite_wvalid),
      .s_lite_wready_o  (lite_wready),
      .s_lite_b_o       (lite_b),
      .s_lite_bvalid_o  (lite_bvalid),
      .s_lite_bready_i  (lite_bready),
      .s_lite_ar_i      (lite_ar),
      .s_lite_arvalid_i (lite_arvalid),
      .s_lite_arready_o (lite_arready),
      .s_lite_r_o       (lite_r),
      .s_lite_rvalid_o  (lite_rvalid),
      .s_lite_rready_i  (lite_rready),
      .m_axi_ar_o       (axi_ar),
      .m_axi_arvalid_o  (axi_arvalid),
      .m_axi_arready_i  (axi_arready),
      .m_axi_r_i        (axi_r),
      .m_axi_rvalid_i   (axi_rvalid),
      .m_axi_rready_o   (axi_rready),
      .m_axis_tdata_o   (tdata),
      .m_axis_tlast_o   (tlast),
      .m_axis_tvalid_o  (tvalid),
      .m_axis_tready_i  (tready)
   );

   dma_axi_mem mem_i (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .ar_i      (axi_ar),
      .arvalid_i (axi_arvalid),
      .arready_o (axi_arready),
      .r_o       (axi_r),
      .rvalid_o  (axi_rvalid),
      .rready_i  (axi_rready)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic expect_equal(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act) else
         report_failure($sformatf("mismatch %s %s: expected %0h actual %0h",
                                  name, what, exp, act));
   endtask

   task automatic lite_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      lite_aw      <= '{addr: `DMA_ADDR_W'(addr)};
      lite_w       <= '{data: data};
      lite_awvalid <= 1'b1;
      lite_wvalid  <= 1'b1;
      do begin
         @(posedge clk);
      end while (!lite_awready);
      assert (lite_wready) else
         report_failure("write data was not taken together with the write address");
      lite_awvalid <= 1'b0;
      lite_wvalid  <= 1'b0;
      @(posedge clk);
      assert (lite_bvalid) else
         report_failure("no write response in the cycle after the write was accepted");
      expect_equal(cur_test, "BRESP OKAY", 32'h0, 32'(lite_b.resp));
   endtask

   task automatic lite_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge clk);
      lite_ar      <= '{addr: `DMA_ADDR_W'(addr)};
      lite_arvalid <= 1'b1;
      do begin
         @(posedge clk);
      end while (!lite_arready);
      lite_arvalid <= 1'b0;
      @(posedge clk);
      assert (lite_rvalid) else
         report_failure("no read data in the cycle after the read was accepted");
      expect_equal(cur_test, "RRESP OKAY", 32'h0, 32'(lite_r.resp));
      data = lite_r.data;
   endtask

   task automatic wait_idle();
      logic [31:0] ctrl;
      ctrl = 32'h1;
      while (ctrl[0]) begin
         lite_read(CSR_CTRL, ctrl);
      end
   endtask

   // Takes words until tlast, tready random or held high
   task automatic collect_stream(input int len, input bit rand_ready);
      bit done;
      done = 1'b0;
      got_data.delete();
      got_last.delete();
      tready <= 1'b1;
      while (!done) begin
         @(posedge clk);
         if (tvalid && tready) begin
            got_data.push_back(tdata);
            got_last.push_back(tlast);
            done = tlast;
            assert (got_data.size() <= len) else
               report_failure("more stream words arrived than the transfer length");
         end
         if (done) begin
            tready <= 1'b0;
         end else if (rand_ready) begin
            tready <= ($random(seed) & 1) != 0;
         end else begin
            tready <= 1'b1;
         end
      end
   endtask

   task automatic scoreboard_stream(input string name, input logic [31:0] base, input int len);
      logic [31:0] exp_addr;
      int          k;
      expect_equal(name, "word count", 32'(len), 32'(got_data.size()));
      for (k = 0; k < len; k++) begin
         exp_addr = base + 32'(4 * k);
         // Memory content rule
         expect_equal(name, "stream data", exp_addr ^ 32'hc0de0000, got_data[k]);
         expect_equal(name, "tlast", 32'(k == len - 1), 32'(got_last[k]));
      end
   endtask

   // Full bursts of maxlen, remainder last, contiguous addresses
   task automatic audit_bursts(input string name, input int first, input logic [31:0] base,
                               input int len, input int maxlen);
      int          remaining;
      int          idx;
      int          blen;
      logic [31:0] addr;
      remaining = len;
      idx       = first;
      addr      = base;
      while (remaining > 0) begin
         blen = (remaining < maxlen) ? remaining : maxlen;
         assert (idx < mem_i.log_cnt) else
            report_failure($sformatf("%s: fewer AR requests than expected", name));
         expect_equal(name, "AR address", addr, mem_i.log_addr[idx]);
         expect_equal(name, "AR length", 32'(blen), 32'(mem_i.log_len[idx]) + 32'd1);
         // Four-byte beats in INCR bursts
         expect_equal(name, "AR size and burst", 32'({3'd2, 2'd1}),
                      32'(mem_i.log_attr[idx]));
         addr      = addr + 32'(4 * blen);
         remaining = remaining - blen;
         idx       = idx + 1;
      end
      expect_equal(name, "AR count", 32'(idx - first), 32'(mem_i.log_cnt - first));
   endtask

   task automatic run_transfer(input string name, input logic [31:0] base, input int len,
                               input int maxlen, input bit rand_ready, input bit restart);
      int          first;
      logic [31:0] ctrl;
      cur_test = name;
      first    = mem_i.log_cnt;
      lite_write(CSR_ADDR, base);
      lite_write(CSR_LEN, 32'(len));
      lite_write(CSR_MAXLEN, 32'(maxlen));
      lite_write(CSR_CTRL, 32'h1);
      if (restart) begin
         lite_read(CSR_CTRL, ctrl);
         expect_equal(name, "busy", 32'h1, ctrl);
         lite_write(CSR_CTRL, 32'h1);
      end
      collect_stream(len, rand_ready);
      wait_idle();
      repeat (20) @(posedge clk);
      assert (!tvalid) else
         report_failure($sformatf("%s: stream still valid after the final word", name));
      scoreboard_stream(name, base, len);
      audit_bursts(name, first, base, len, maxlen);
   endtask

   task automatic reset_and_registers();
      logic [31:0] rd;
      cur_test = "reset_and_registers";
      assert (!tvalid) else report_failure("tvalid is high after reset");
      lite_read(CSR_CTRL, rd);
      expect_equal("reset_and_registers", "busy", 32'h0, rd);
      lite_write(CSR_ADDR, 32'h1234_5670);
      lite_read(CSR_ADDR, rd);
      expect_equal("reset_and_registers", "ADDR", 32'h1234_5670, rd);
      lite_write(CSR_LEN, 32'h0000_00ab);
      lite_read(CSR_LEN, rd);
      expect_equal("reset_and_registers", "LEN", 32'h0000_00ab, rd);
      lite_write(CSR_MAXLEN, 32'd0);
      lite_read(CSR_MAXLEN, rd);
      expect_equal("reset_and_registers", "MAXLEN 0", 32'd1, rd);
      lite_write(CSR_MAXLEN, 32'd5);
      lite_read(CSR_MAXLEN, rd);
      expect_equal("reset_and_registers", "MAXLEN 5", 32'd5, rd);
      lite_write(CSR_MAXLEN, 32'd40);
      lite_read(CSR_MAXLEN, rd);
      expect_equal("reset_and_registers", "MAXLEN 40", 32'd16, rd);
   endtask

   task automatic short_transfer();
      run_transfer("short_transfer", 32'h0000_1000, 6, 16, 1'b0, 1'b0);
   endtask

   task automatic split_transfer();
      run_transfer("split_transfer", 32'h0002_0040, 37, 8, 1'b0, 1'b0);
   endtask

   task automatic back_pressure();
      run_transfer("back_pressure", 32'h0010_0000, 100, 16, 1'b1, 1'b0);
   endtask

   task automatic control_edge_cases();
      logic [31:0] rd;
      int          first;
      // Long enough to stall on a full FIFO while tready is low
      run_transfer("control_edge_cases", 32'h0003_0000, 60, 4, 1'b0, 1'b1);
      lite_read(CSR_REMAIN, rd);
      expect_equal("control_edge_cases", "REMAIN", 32'h0, rd);
      first = mem_i.log_cnt;
      lite_write(CSR_LEN, 32'd0);
      lite_write(CSR_CTRL, 32'h1);
      repeat (50) begin
         @(posedge clk);
         assert (!tvalid) else report_failure("a length-0 start produced a stream word");
      end
      expect_equal("control_edge_cases", "AR count", 32'(first), 32'(mem_i.log_cnt));
      lite_read(CSR_CTRL, rd);
      expect_equal("control_edge_cases", "busy", 32'h0, rd);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      report_failure("watchdog timeout, the tests did not finish in time");
   end

   initial begin
      seed         = 32'h6ab1f12f;
      cur_test     = "reset";
      rst_n        <= 1'b0;
      lite_aw      <= '0;
      lite_awvalid <= 1'b0;
      lite_w       <= '0;
      lite_wvalid  <= 1'b0;
      lite_bready  <= 1'b1;
      lite_ar      <= '0;
      lite_arvalid <= 1'b0;
      lite_rready  <= 1'b1;
      tready       <= 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      reset_and_registers();
      short_transfer();
      split_transfer();
      back_pressure();
      control_edge_cases();
      $display("PASS: all tests");
      $finish;
   end

endmodule

/* include/dma_macros.svh */
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Bus widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_ID_W 2

// Burst length field, 16 beats at most
`define DMA_LEN_W 4

// Transfer length in words
`define DMA_RLEN_W 16

// Data FIFO holds 32 beats
`define DMA_FIFO_AW 5

// Command FIFO holds 2 bursts
`define DMA_CMD_AW 1

`endif

/* run.sh */
#!/bin/sh
# Build and run the DMA read engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dma_tb \
   -f sources.f --Mdir obj_dir -o dma_tb_sim

./obj_dir/dma_tb_sim

/* sources.f */
+incdir+include
design/dma_axi_pkg.sv
design/dma_ctrl_pkg.sv
design/dma_csr.sv
design/dma_burst_sched.sv
design/dma_sync_fifo.sv
design/dma_axi_rd_master.sv
design/dma_read_top.sv
dv/dma_axi_mem.sv
dv/dma_tb.sv
